// ==== source/icache_pkg.sv ====
/* instruction cache shared constants */

package icache_pkg;

    // fetch and fill addressing
    localparam int ADDR_WIDTH  = 32;
    localparam int BLOCK_BITS  = 64;
    localparam int OFFSET_BITS = 3;    // byte offset in a block, ignored on lookup

    // apb register port
    localparam int APB_DATA_WIDTH = 32;
    localparam int APB_ADDR_WIDTH = 4;

    localparam logic [APB_ADDR_WIDTH-1:0] REG_FILL_ADDR    = 4'h0;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_FILL_DATA_LO = 4'h4;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_FILL_DATA_HI = 4'h8;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL         = 4'hC;

    // control register fields
    localparam int CTRL_WAY_LSB    = 0;
    localparam int CTRL_WAY_BITS   = 4;
    // write-only command bits, read back as zero
    localparam int CTRL_COMMIT_BIT = 8;
    localparam int CTRL_INVAL_BIT  = 9;

endpackage

// ==== source/way_array.sv ====
/* 1r1w storage array */

`timescale 1ns/100ps

module way_array #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 64
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  entry_t                   wr_entry,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output entry_t                   rd_entry
);

    // behavioural model of a tag or data sram macro
    entry_t mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    // registered read, same-address write gives the old entry
    always_ff @(posedge clk) begin
        rd_entry <= mem[rd_addr];
    end

endmodule

// ==== source/icache_front.sv ====
/* icache apb registers and lookup front end */

`timescale 1ns/100ps

module icache_front #(
    parameter int NUM_WAYS = 2,
    parameter int NUM_SETS = 64,
    localparam int IDX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = icache_pkg::ADDR_WIDTH - IDX_BITS - icache_pkg::OFFSET_BITS
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // apb slave
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [icache_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [icache_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [icache_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    // lookup port
    input  logic                                  lookup_valid,
    input  logic [icache_pkg::ADDR_WIDTH-1:0]     lookup_addr,
    // to the ways
    output logic [IDX_BITS-1:0]                   rd_index,
    output logic [TAG_BITS-1:0]                   cmp_tag,
    output logic                                  lookup_q,
    output logic [NUM_WAYS-1:0]                   wr_en_way,
    output logic [IDX_BITS-1:0]                   wr_index,
    output logic [TAG_BITS-1:0]                   wr_tag,
    output logic [icache_pkg::BLOCK_BITS-1:0]     wr_data,
    output logic                                  inval_all
);

    logic [icache_pkg::ADDR_WIDTH-1:0]     fill_addr;
    logic [icache_pkg::APB_DATA_WIDTH-1:0] fill_lo;
    logic [icache_pkg::APB_DATA_WIDTH-1:0] fill_hi;
    logic [icache_pkg::CTRL_WAY_BITS-1:0]  way_q;
    logic [icache_pkg::CTRL_WAY_BITS-1:0]  ctrl_way;
    logic apb_acc, apb_wr, is_ctrl, unmapped, way_bad, ctrl_ok;

    // no wait states
    assign pready  = 1'b1;
    assign apb_acc = psel && penable;
    assign apb_wr  = apb_acc && pwrite;

    // offset decode
    assign is_ctrl  = (paddr == icache_pkg::REG_CTRL);
    assign unmapped = (paddr != icache_pkg::REG_FILL_ADDR)
                   && (paddr != icache_pkg::REG_FILL_DATA_LO)
                   && (paddr != icache_pkg::REG_FILL_DATA_HI)
                   && !is_ctrl;

    // way index range check on control writes
    assign ctrl_way = pwdata[icache_pkg::CTRL_WAY_LSB +: icache_pkg::CTRL_WAY_BITS];
    assign way_bad  = (int'(ctrl_way) >= NUM_WAYS);
    assign ctrl_ok  = apb_wr && is_ctrl && !way_bad;

    assign pslverr = apb_acc && (unmapped || (pwrite && is_ctrl && way_bad));

    // fill registers and last accepted way
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_addr <= '0;
            fill_lo   <= '0;
            fill_hi   <= '0;
            way_q     <= '0;
        end else if (apb_wr) begin
            case (paddr)
                icache_pkg::REG_FILL_ADDR:    fill_addr <= pwdata;
                icache_pkg::REG_FILL_DATA_LO: fill_lo   <= pwdata;
                icache_pkg::REG_FILL_DATA_HI: fill_hi   <= pwdata;
                icache_pkg::REG_CTRL: begin
                    if (!way_bad) begin
                        way_q <= ctrl_way;
                    end
                end
                default: ;
            endcase
        end
    end

    // readback, command bits stay zero
    always_comb begin
        prdata = '0;
        case (paddr)
            icache_pkg::REG_FILL_ADDR:    prdata = fill_addr;
            icache_pkg::REG_FILL_DATA_LO: prdata = fill_lo;
            icache_pkg::REG_FILL_DATA_HI: prdata = fill_hi;
            icache_pkg::REG_CTRL:
                prdata[icache_pkg::CTRL_WAY_LSB +: icache_pkg::CTRL_WAY_BITS] = way_q;
            default: prdata = '0;
        endcase
    end

    // invalidate beats commit
    assign inval_all = ctrl_ok && pwdata[icache_pkg::CTRL_INVAL_BIT];

    // one-hot commit strobe, lands on the completing apb edge
    always_comb begin
        for (int i = 0; i < NUM_WAYS; i++) begin
            wr_en_way[i] = ctrl_ok && pwdata[icache_pkg::CTRL_COMMIT_BIT]
                        && !pwdata[icache_pkg::CTRL_INVAL_BIT]
                        && (int'(ctrl_way) == i);
        end
    end

    // fill address split
    assign wr_index = fill_addr[icache_pkg::OFFSET_BITS +: IDX_BITS];
    assign wr_tag   = fill_addr[icache_pkg::ADDR_WIDTH-1 -: TAG_BITS];
    assign wr_data  = {fill_hi, fill_lo};

    // lookup index goes straight to the arrays
    assign rd_index = lookup_addr[icache_pkg::OFFSET_BITS +: IDX_BITS];

    // tag and valid delayed to meet the array read
    always_ff @(posedge clk) begin
        cmp_tag <= lookup_addr[icache_pkg::ADDR_WIDTH-1 -: TAG_BITS];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= lookup_valid;
        end
    end

endmodule

// ==== source/icache_way.sv ====
/* single icache way */

`timescale 1ns/100ps

module icache_way #(
    parameter int NUM_SETS = 64,
    localparam int IDX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = icache_pkg::ADDR_WIDTH - IDX_BITS - icache_pkg::OFFSET_BITS
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [IDX_BITS-1:0]               rd_index,
    input  logic [TAG_BITS-1:0]               cmp_tag,
    input  logic                              wr_en,
    input  logic [IDX_BITS-1:0]               wr_index,
    input  logic [TAG_BITS-1:0]               wr_tag,
    input  logic [icache_pkg::BLOCK_BITS-1:0] wr_data,
    input  logic                              inval_all,
    output logic                              hit,
    output logic [icache_pkg::BLOCK_BITS-1:0] data
);

    logic [TAG_BITS-1:0] tag_q;
    logic [NUM_SETS-1:0] valid;
    logic                valid_q;

    // tag storage
    way_array #(.entry_t(logic [TAG_BITS-1:0]), .DEPTH(NUM_SETS)) u_tag_arr (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_index),
        .wr_entry (wr_tag),
        .rd_addr  (rd_index),
        .rd_entry (tag_q)
    );

    // block storage
    way_array #(.entry_t(logic [icache_pkg::BLOCK_BITS-1:0]), .DEPTH(NUM_SETS)) u_data_arr (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_index),
        .wr_entry (wr_data),
        .rd_addr  (rd_index),
        .rd_entry (data)
    );

    // valid flops, one per set, so a flush is one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid   <= '0;
            valid_q <= 1'b0;
        end else begin
            if (inval_all) begin
                valid <= '0;
            end else if (wr_en) begin
                valid[wr_index] <= 1'b1;
            end
            // sampled pre-update, same as the arrays
            valid_q <= valid[rd_index];
        end
    end

    assign hit = valid_q && (tag_q == cmp_tag);

endmodule

// ==== source/icache_way_select.sv ====
/* icache hit resolve and data mux */

`timescale 1ns/100ps

module icache_way_select #(
    parameter int NUM_WAYS = 2
) (
    input  logic                                       lookup_q,
    input  logic [NUM_WAYS-1:0]                        way_hit,
    input  logic [NUM_WAYS*icache_pkg::BLOCK_BITS-1:0] way_data,
    output logic                                       resp_valid,
    output logic                                       lookup_hit,
    output logic [icache_pkg::BLOCK_BITS-1:0]          lookup_data
);

    logic [NUM_WAYS-1:0] hits;

    // response follows the delayed lookup strobe
    assign resp_valid = lookup_q;

    // ignore stale compares when no lookup is in flight
    assign hits = way_hit & {NUM_WAYS{lookup_q}};

    // lowest way wins, walk down so it assigns last
    always_comb begin
        lookup_hit  = 1'b0;
        lookup_data = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (hits[i]) begin
                lookup_hit  = 1'b1;
                lookup_data = way_data[i*icache_pkg::BLOCK_BITS +: icache_pkg::BLOCK_BITS];
            end
        end
    end

endmodule

// ==== source/icache_top.sv ====
/* instruction cache top */

`timescale 1ns/100ps

module icache_top #(
    parameter int NUM_WAYS = 2,
    parameter int NUM_SETS = 64,
    localparam int IDX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = icache_pkg::ADDR_WIDTH - IDX_BITS - icache_pkg::OFFSET_BITS
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [icache_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [icache_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [icache_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    input  logic                                  lookup_valid,
    input  logic [icache_pkg::ADDR_WIDTH-1:0]     lookup_addr,
    output logic                                  resp_valid,
    output logic                                  lookup_hit,
    output logic [icache_pkg::BLOCK_BITS-1:0]     lookup_data
);

    logic [IDX_BITS-1:0]                        rd_index;
    logic [TAG_BITS-1:0]                        cmp_tag;
    logic                                       lookup_q;
    logic [NUM_WAYS-1:0]                        wr_en_way;
    logic [IDX_BITS-1:0]                        wr_index;
    logic [TAG_BITS-1:0]                        wr_tag;
    logic [icache_pkg::BLOCK_BITS-1:0]          wr_data;
    logic                                       inval_all;
    logic [NUM_WAYS-1:0]                        way_hit;
    logic [NUM_WAYS*icache_pkg::BLOCK_BITS-1:0] way_data;

    icache_front #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) u_front (
        .clk, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .lookup_valid, .lookup_addr,
        .rd_index, .cmp_tag, .lookup_q,
        .wr_en_way, .wr_index, .wr_tag, .wr_data, .inval_all
    );

    // identical ways, shared read and fill buses
    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        icache_way #(.NUM_SETS(NUM_SETS)) u_way (
            .clk, .rst_n, .rd_index, .cmp_tag,
            .wr_en     (wr_en_way[g]),
            .wr_index, .wr_tag, .wr_data, .inval_all,
            .hit       (way_hit[g]),
            .data      (way_data[g*icache_pkg::BLOCK_BITS +: icache_pkg::BLOCK_BITS])
        );
    end

    icache_way_select #(.NUM_WAYS(NUM_WAYS)) u_select (
        .lookup_q, .way_hit, .way_data,
        .resp_valid, .lookup_hit, .lookup_data
    );

endmodule

// ==== dv/icache_checker.sv ====
/* icache lookup and apb assertions */

`timescale 1ns/100ps

module icache_checker (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              lookup_valid,
    input logic                              resp_valid,
    input logic                              lookup_hit,
    input logic [icache_pkg::BLOCK_BITS-1:0] lookup_data,
    input logic                              psel,
    input logic                              penable,
    input logic                              pready,
    input logic                              pslverr
);

    // response strobe trails the request by one cycle
    a_resp_follows: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid == $past(lookup_valid))
        else $error("resp_valid does not follow lookup_valid by one cycle");

    // no hit without a response
    a_hit_needs_resp: assert property (@(posedge clk) disable iff (!rst_n)
        lookup_hit |-> resp_valid)
        else $error("lookup_hit high while resp_valid is low");

    // slave error only in a ready access phase
    a_err_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable && pready))
        else $error("pslverr raised outside a ready access phase");

    // quiet outputs while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!resp_valid && !lookup_hit && !pslverr && lookup_data == '0))
        else $error("outputs not low during reset");

endmodule

bind icache_top icache_checker u_checker (.*);

// ==== dv/icache_tb.sv ====
/* icache testbench */

`timescale 1ns/100ps

module icache_tb;

    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 64;
    localparam int IDX_BITS   = $clog2(NUM_SETS);
    localparam int OFF        = icache_pkg::OFFSET_BITS;
    localparam int TAG_BITS   = icache_pkg::ADDR_WIDTH - IDX_BITS - OFF;
    localparam int CLK_PERIOD = 100;
    localparam int EMPTY_LOOKUPS = 20;
    localparam int FILL_COUNT    = 8;
    localparam int STREAM_FILLS  = 40;
    // a fill is four two-cycle apb writes
    localparam int FILL_CYCLES   = 8;
    // stream adds up to 3 idle cycles per fill, 200 covers lookups and register tests
    localparam int TIMEOUT_CYCLES = 2 * (EMPTY_LOOKUPS + FILL_COUNT * (FILL_CYCLES + 2)
                                  + STREAM_FILLS * (FILL_CYCLES + 3) + 8 * FILL_CYCLES + 200);

    logic        clk, rst_n, psel, penable, pwrite, pready, pslverr;
    logic [3:0]  paddr;
    logic [31:0] pwdata, prdata, lookup_addr;
    logic        lookup_valid, resp_valid, lookup_hit;
    logic [63:0] lookup_data;

    // reference model, key is way * NUM_SETS + set
    bit                  m_valid [int];
    logic [TAG_BITS-1:0] m_tag [int];
    logic [63:0]         m_data [int];
    logic [31:0]         m_fill_addr, m_fill_lo, m_fill_hi;
    int                  m_way;

    // stimulus for the next falling edge
    logic        lk_valid_n, ap_psel, ap_penable, ap_pwrite, rand_lookups;
    logic [31:0] lk_addr_n, ap_wdata;
    logic [3:0]  ap_addr;
    logic        exp_valid, exp_hit;
    logic [63:0] exp_data;
    logic [31:0] filled_q [$];
    integer      seed;
    int          checks, errors, test_errs, cycles;
    string       test_name;

    icache_top uut (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .lookup_valid, .lookup_addr, .resp_valid, .lookup_hit, .lookup_data
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // lowest way holding the tag wins
    task automatic predict(input logic [31:0] addr, output logic hit, output logic [63:0] blk);
        int key;
        hit = 1'b0;
        blk = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            key = w * NUM_SETS + int'(addr[OFF +: IDX_BITS]);
            if (!hit && m_valid.exists(key) && m_tag[key] == addr[31 -: TAG_BITS]) begin
                hit = 1'b1;
                blk = m_data[key];
            end
        end
    endtask

    function automatic logic apb_error(input logic wr, input logic [3:0] addr,
                                       input logic [31:0] wdata);
        logic mapped;
        mapped = addr inside {icache_pkg::REG_FILL_ADDR, icache_pkg::REG_FILL_DATA_LO,
                              icache_pkg::REG_FILL_DATA_HI, icache_pkg::REG_CTRL};
        return !mapped || (wr && addr == icache_pkg::REG_CTRL
            && wdata[icache_pkg::CTRL_WAY_LSB +: icache_pkg::CTRL_WAY_BITS] >= NUM_WAYS);
    endfunction

    function automatic logic [31:0] read_value(input logic [3:0] addr);
        case (addr)
            icache_pkg::REG_FILL_ADDR:    return m_fill_addr;
            icache_pkg::REG_FILL_DATA_LO: return m_fill_lo;
            icache_pkg::REG_FILL_DATA_HI: return m_fill_hi;
            icache_pkg::REG_CTRL:         return 32'(m_way);
            default:                      return '0;
        endcase
    endfunction

    // accepted write, model state moves at the completing edge
    task automatic apply_write(input logic [3:0] addr, input logic [31:0] wdata);
        int key;
        case (addr)
            icache_pkg::REG_FILL_ADDR:    m_fill_addr = wdata;
            icache_pkg::REG_FILL_DATA_LO: m_fill_lo = wdata;
            icache_pkg::REG_FILL_DATA_HI: m_fill_hi = wdata;
            default: begin
                m_way = wdata[icache_pkg::CTRL_WAY_LSB +: icache_pkg::CTRL_WAY_BITS];
                key = m_way * NUM_SETS + int'(m_fill_addr[OFF +: IDX_BITS]);
                if (wdata[icache_pkg::CTRL_INVAL_BIT]) begin
                    m_valid.delete();
                    m_tag.delete();
                    m_data.delete();
                end else if (wdata[icache_pkg::CTRL_COMMIT_BIT]) begin
                    m_valid[key] = 1'b1;
                    m_tag[key] = m_fill_addr[31 -: TAG_BITS];
                    m_data[key] = {m_fill_hi, m_fill_lo};
                end
            end
        endcase
    endtask

    // mostly filled addresses with a fresh offset, the rest anywhere
    task automatic pick_lookup();
        logic [31:0] r;
        int idx;
        r = $random(seed);
        lk_valid_n = r[0];
        if (r[2:1] != 2'b00 && filled_q.size() > 0) begin
            idx = $unsigned($random(seed)) % filled_q.size();
            lk_addr_n = {filled_q[idx][31:OFF], r[OFF+2:3]};
        end else begin
            lk_addr_n = $random(seed);
        end
    endtask

    // one clock: check last response, drive the next inputs
    task automatic step();
        logic        p_hit, exp_err;
        logic [63:0] p_blk;
        logic [31:0] exp_rd;
        @(negedge clk);
        check({test_name, " resp_valid"}, exp_valid, resp_valid);
        check({test_name, " lookup_hit"}, exp_hit, lookup_hit);
        check({test_name, " lookup_data"}, exp_data, lookup_data);
        if (rand_lookups) begin
            pick_lookup();
        end
        // lookup sees the cache as before this cycle's apb edge
        predict(lk_addr_n, p_hit, p_blk);
        exp_valid = lk_valid_n;
        exp_hit = lk_valid_n && p_hit;
        exp_data = exp_hit ? p_blk : '0;
        lookup_valid = lk_valid_n;
        lookup_addr = lk_addr_n;
        psel = ap_psel;
        penable = ap_penable;
        pwrite = ap_pwrite;
        paddr = ap_addr;
        pwdata = ap_wdata;
        if (ap_psel && ap_penable) begin
            exp_err = apb_error(ap_pwrite, ap_addr, ap_wdata);
            exp_rd = read_value(ap_addr);
            // apb outputs are combinational, look mid phase
            #(CLK_PERIOD / 4);
            check({test_name, " pready"}, 1'b1, pready);
            check({test_name, " pslverr"}, exp_err, pslverr);
            if (!ap_pwrite && !exp_err) begin
                check({test_name, " prdata"}, exp_rd, prdata);
            end
            if (ap_pwrite && !exp_err) begin
                apply_write(ap_addr, ap_wdata);
            end
        end
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata);
        ap_psel = 1'b1;
        ap_penable = 1'b0;
        ap_pwrite = wr;
        ap_addr = addr;
        ap_wdata = wdata;
        step();
        ap_penable = 1'b1;
        step();
        ap_psel = 1'b0;
        ap_penable = 1'b0;
    endtask

    task automatic fill(input int way, input logic [31:0] addr, input logic [63:0] blk);
        apb_access(1'b1, icache_pkg::REG_FILL_ADDR, addr);
        apb_access(1'b1, icache_pkg::REG_FILL_DATA_LO, blk[31:0]);
        apb_access(1'b1, icache_pkg::REG_FILL_DATA_HI, blk[63:32]);
        apb_access(1'b1, icache_pkg::REG_CTRL, (32'h1 << icache_pkg::CTRL_COMMIT_BIT) | way);
        filled_q.push_back(addr);
    endtask

    task automatic lookup(input logic [31:0] addr);
        lk_valid_n = 1'b1;
        lk_addr_n = addr;
        step();
        lk_valid_n = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        rand_lookups = 1'b0;
        lk_valid_n = 1'b0;
        step();
        $display("test %-14s %s, %0d errors", test_name,
                 (errors == test_errs) ? "ok" : "failed", errors - test_errs);
    endtask

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [31:0]         a;
        logic [63:0]         d;
        logic [TAG_BITS-1:0] tag;
        logic [IDX_BITS-1:0] set;
        int                  n;
        seed = 32'h4acc;
        {rst_n, psel, penable, pwrite, paddr, pwdata, lookup_valid, lookup_addr} = '0;
        {lk_valid_n, lk_addr_n, ap_psel, ap_penable, ap_pwrite, ap_addr, ap_wdata} = '0;
        {exp_valid, exp_hit, exp_data, rand_lookups} = '0;
        {m_fill_addr, m_fill_lo, m_fill_hi, m_way, checks, errors} = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        begin_test("empty_lookup");
        rand_lookups = 1'b1;
        repeat (EMPTY_LOOKUPS) step();
        end_test();

        begin_test("fill_lookup");
        repeat (FILL_COUNT) begin
            a = $random(seed);
            d = {$random(seed), $random(seed)};
            fill($unsigned($random(seed)) % NUM_WAYS, a, d);
        end
        for (int i = 0; i < filled_q.size(); i++) begin
            a = filled_q[i];
            lookup({a[31:OFF], OFF'($random(seed))});
            // same set, other tag
            lookup({~a[31 -: TAG_BITS], a[31-TAG_BITS:0]});
        end
        end_test();

        begin_test("way_priority");
        set = $random(seed);
        tag = $random(seed);
        for (int w = 0; w < NUM_WAYS; w++) begin
            fill(w, {tag + TAG_BITS'(w), set, OFF'(0)}, {$random(seed), $random(seed)});
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            lookup({tag + TAG_BITS'(w), set, OFF'(0)});
        end
        // one tag in the top and the bottom way of the next set
        set = set + 1'b1;
        fill(NUM_WAYS - 1, {tag, set, OFF'(0)}, {$random(seed), $random(seed)});
        fill(0, {tag, set, OFF'(0)}, {$random(seed), $random(seed)});
        lookup({tag, set, OFF'(5)});
        end_test();

        begin_test("random_stream");
        rand_lookups = 1'b1;
        repeat (STREAM_FILLS) begin
            a = $random(seed);
            // about half the fills hit a set already in use
            if (a[0] && filled_q.size() > 0) begin
                n = $unsigned($random(seed)) % filled_q.size();
                a[OFF +: IDX_BITS] = filled_q[n][OFF +: IDX_BITS];
            end
            fill($unsigned($random(seed)) % NUM_WAYS, a, {$random(seed), $random(seed)});
            repeat ($unsigned($random(seed)) % 4) step();
        end
        end_test();

        begin_test("invalidate");
        apb_access(1'b1, icache_pkg::REG_CTRL, 32'h1 << icache_pkg::CTRL_INVAL_BIT);
        n = filled_q.size();
        for (int i = 0; i < n; i++) begin
            lookup(filled_q[i]);
        end
        for (int i = 0; i < 4; i++) begin
            fill(i % NUM_WAYS, filled_q[i], {$random(seed), $random(seed)});
        end
        for (int i = 0; i < 4; i++) begin
            lookup(filled_q[i]);
        end
        // commit and invalidate together, invalidate wins
        apb_access(1'b1, icache_pkg::REG_CTRL, (32'h1 << icache_pkg::CTRL_COMMIT_BIT)
                   | (32'h1 << icache_pkg::CTRL_INVAL_BIT));
        for (int i = 0; i < 4; i++) begin
            lookup(filled_q[i]);
        end
        end_test();

        begin_test("apb_regs");
        a = $random(seed);
        d = {$random(seed), $random(seed)};
        apb_access(1'b1, icache_pkg::REG_FILL_ADDR, a);
        apb_access(1'b1, icache_pkg::REG_FILL_DATA_LO, d[31:0]);
        apb_access(1'b1, icache_pkg::REG_FILL_DATA_HI, d[63:32]);
        apb_access(1'b0, icache_pkg::REG_FILL_ADDR, '0);
        apb_access(1'b0, icache_pkg::REG_FILL_DATA_LO, '0);
        apb_access(1'b0, icache_pkg::REG_FILL_DATA_HI, '0);
        apb_access(1'b1, icache_pkg::REG_CTRL,
                   (32'h1 << icache_pkg::CTRL_COMMIT_BIT) | (NUM_WAYS - 1));
        filled_q.push_back(a);
        apb_access(1'b0, icache_pkg::REG_CTRL, '0);
        // new data, then a rejected commit must not store it
        apb_access(1'b1, icache_pkg::REG_FILL_DATA_LO, ~d[31:0]);
        apb_access(1'b1, icache_pkg::REG_CTRL, (32'h1 << icache_pkg::CTRL_COMMIT_BIT)
                   | (NUM_WAYS + $unsigned($random(seed)) % (16 - NUM_WAYS)));
        apb_access(1'b0, icache_pkg::REG_CTRL, '0);
        // unmapped offset that aliases ctrl on a partial decode, valid way 0 flush
        apb_access(1'b1, 4'hE, 32'h1 << icache_pkg::CTRL_INVAL_BIT);
        apb_access(1'b0, 4'h2, '0);
        lookup(a);
        end_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/icache_pkg.sv
source/way_array.sv
source/icache_front.sv
source/icache_way.sv
source/icache_way_select.sv
source/icache_top.sv
dv/icache_checker.sv
dv/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - source/icache_pkg.sv
      - source/way_array.sv
      - source/icache_front.sv
      - source/icache_way.sv
      - source/icache_way_select.sv
      - source/icache_top.sv
  - target: test
    files:
      - dv/icache_checker.sv
      - dv/icache_tb.sv
